// ==== compile.f ====
design/soc_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/wb_debug_bridge.sv
design/wb_addr_decoder.sv
design/scratch_ram.sv
design/sys_regs.sv
design/soc_fpga_top.sv
sim/tb_soc_fpga_top.sv

// ==== sim/soc_testdata.txt ====
# num opcode addr wdata exp_reply exp_rdata, all hex except num
# wdata xxxxxxxx is a random word, exp_rdata xxxxxxxx comes from the RAM model, -------- is none
1  57 00 11223344 4B --------
2  57 3F A5A55A5A 4B --------
3  57 01 xxxxxxxx 4B --------
4  57 02 xxxxxxxx 4B --------
5  57 20 xxxxxxxx 4B --------
6  57 3E xxxxxxxx 4B --------
7  52 00 -------- 4B 11223344
8  52 3F -------- 4B A5A55A5A
9  52 01 -------- 4B xxxxxxxx
10 52 02 -------- 4B xxxxxxxx
11 52 20 -------- 4B xxxxxxxx
12 52 3E -------- 4B xxxxxxxx
13 52 80 -------- 4B 5AC00001
14 57 80 DEADBEEF 4B --------
15 52 80 -------- 4B 5AC00001
16 57 81 000000A5 4B --------
17 52 81 -------- 4B 000000A5
18 57 81 7E5C33A5 4B --------
19 52 81 -------- 4B 000000A5
20 57 40 CAFEF00D 45 --------
21 52 40 -------- 45 --------
22 57 FF 0BADC0DE 45 --------
23 52 FF -------- 45 --------
24 52 00 -------- 4B 11223344
25 52 3F -------- 4B A5A55A5A
26 3C 00 -------- 3F --------
27 52 01 -------- 4B xxxxxxxx

// ==== sim/tb_soc_fpga_top.sv ====
`timescale 1ns/1ps

module tb_soc_fpga_top import soc_pkg::*; ();

   localparam int MAX_TESTS  = 64;
   localparam int BYTE_CLKS  = 10 * CLKS_PER_BIT;
   // Longest wait for the start bit of a reply byte
   localparam int REPLY_WAIT = 4 * BYTE_CLKS;
   localparam int QUIET_CLKS = 2 * BYTE_CLKS;

   logic       ref_clk = 1'b0;
   logic       arst_n;
   logic       uart_rx;
   logic       uart_tx;
   logic [7:0] led;

   // Test table loaded from the data file
   int                   n_tests;
   int                   t_num    [MAX_TESTS];
   logic [7:0]           t_op     [MAX_TESTS];
   logic [WB_ADDR_W-1:0] t_adr    [MAX_TESTS];
   logic [WB_DATA_W-1:0] t_wdat   [MAX_TESTS];
   logic                 t_wrand  [MAX_TESTS];
   logic [7:0]           t_rsp    [MAX_TESTS];
   logic [WB_DATA_W-1:0] t_rdat   [MAX_TESTS];
   logic                 t_rmodel [MAX_TESTS];

   logic [WB_DATA_W-1:0] ram_model [RAM_WORDS];
   integer               seed        = 32'h6786f36b;
   int                   test_errors = 0;
   int                   pass_count  = 0;
   int                   fail_count  = 0;
   longint               watchdog_ns = 0;

   soc_fpga_top i_dut (
      .ref_clk ( ref_clk ),
      .arst_n  ( arst_n  ),
      .uart_rx ( uart_rx ),
      .uart_tx ( uart_tx ),
      .led     ( led     )
   );

   always #5 ref_clk = ~ref_clk;

   // ------------------------------------------------------------------------
   // Checking helpers
   // ------------------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      if (got !== exp) begin
         $display("ERROR %s exp %h got %h", name, exp, got);
         test_errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      test_errors++;
   endtask

   task automatic record_result(input int num, input string what);
      if (test_errors == 0) begin
         pass_count++;
         $display("test %0d %s: ok", num, what);
      end else begin
         fail_count++;
         $display("test %0d %s: FAILED with %0d errors", num, what, test_errors);
      end
   endtask

   // ------------------------------------------------------------------------
   // UART line driver and monitor
   // ------------------------------------------------------------------------
   // One idle bit ahead of each frame lets the receiver rearm
   task automatic send_byte(input logic [7:0] data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      repeat (CLKS_PER_BIT) @(posedge ref_clk);
      for (int i = 0; i < 10; i++) begin
         @(posedge ref_clk);
         #1 uart_rx = frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge ref_clk);
      end
   endtask

   // Samples on the falling edge, in the middle of each bit
   task automatic receive_byte(output logic [7:0] data);
      int waited;
      waited = 0;
      data   = 8'h00;
      @(negedge ref_clk);
      while (uart_tx !== 1'b0 && waited < REPLY_WAIT) begin
         @(negedge ref_clk);
         waited++;
      end
      if (uart_tx !== 1'b0) begin
         report_failure("no reply byte appeared on uart_tx in time");
      end else begin
         repeat (CLKS_PER_BIT / 2) @(negedge ref_clk);
         if (uart_tx !== 1'b0) begin
            report_failure("start bit on uart_tx ended early");
         end
         for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge ref_clk);
            data[i] = uart_tx;
         end
         repeat (CLKS_PER_BIT) @(negedge ref_clk);
         if (uart_tx !== 1'b1) begin
            report_failure("stop bit on uart_tx was low");
         end
      end
   endtask

   task automatic expect_quiet();
      for (int c = 0; c < QUIET_CLKS; c++) begin
         @(negedge ref_clk);
         if (uart_tx !== 1'b1) begin
            report_failure("uart_tx sent more than the single reply byte");
            return;
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // Test table and test sequences
   // ------------------------------------------------------------------------
   task automatic load_tests();
      int               fd;
      int               n_fields;
      int               num;
      logic [7:0]       op;
      logic [7:0]       adr;
      logic [7:0]       rsp;
      logic [63:0]      wd_s;
      logic [63:0]      rd_s;
      logic [31:0]      word;
      logic [8*120-1:0] line_buf;
      n_tests = 0;
      fd = $fopen("sim/soc_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open the data file sim/soc_testdata.txt");
         return;
      end
      while ($fgets(line_buf, fd) != 0) begin
         n_fields = $sscanf(line_buf, "%d %h %h %s %h %s", num, op, adr, wd_s, rsp, rd_s);
         // Comment lines do not scan as six fields
         if (n_fields == 6 && n_tests < MAX_TESTS) begin
            t_num[n_tests]    = num;
            t_op[n_tests]     = op;
            t_adr[n_tests]    = adr;
            t_rsp[n_tests]    = rsp;
            t_wrand[n_tests]  = (wd_s == "xxxxxxxx");
            t_rmodel[n_tests] = (rd_s == "xxxxxxxx");
            word = '0;
            if (wd_s != "xxxxxxxx" && wd_s != "--------") begin
               n_fields = $sscanf(wd_s, "%h", word);
            end
            t_wdat[n_tests] = word;
            word = '0;
            if (rd_s != "xxxxxxxx" && rd_s != "--------") begin
               n_fields = $sscanf(rd_s, "%h", word);
            end
            t_rdat[n_tests] = word;
            n_tests++;
         end
      end
      $fclose(fd);
   endtask

   task automatic check_idle_after_reset();
      test_errors = 0;
      for (int c = 0; c < 4 * BYTE_CLKS && test_errors == 0; c++) begin
         @(negedge ref_clk);
         check_value("uart_tx", 1'b1, uart_tx);
         check_value("led", 8'h00, led);
      end
      record_result(0, "idle after reset");
   endtask

   task automatic run_test(input int i);
      logic [WB_DATA_W-1:0] wdat;
      logic [WB_DATA_W-1:0] rdat;
      logic [WB_DATA_W-1:0] exp_rdat;
      logic [7:0]           rsp;
      logic [7:0]           b;
      test_errors = 0;
      wdat = t_wdat[i];
      if (t_wrand[i]) begin
         wdat = $random(seed);
      end
      send_byte(t_op[i]);
      if (t_op[i] == CMD_WRITE || t_op[i] == CMD_READ) begin
         send_byte(t_adr[i]);
      end
      // Write data goes most significant byte first
      if (t_op[i] == CMD_WRITE) begin
         for (int k = 3; k >= 0; k--) begin
            send_byte(wdat[8*k +: 8]);
         end
      end
      receive_byte(rsp);
      check_value("reply", t_rsp[i], rsp);
      if (t_op[i] == CMD_READ && t_rsp[i] == RSP_OK) begin
         rdat = '0;
         for (int k = 0; k < 4; k++) begin
            receive_byte(b);
            rdat = {rdat[23:0], b};
         end
         exp_rdat = t_rdat[i];
         if (t_rmodel[i]) begin
            exp_rdat = ram_model[t_adr[i][RAM_ADR_W-1:0]];
         end
         check_value("rdata", exp_rdat, rdat);
      end else begin
         expect_quiet();
      end
      if (t_op[i] == CMD_WRITE && t_rsp[i] == RSP_OK) begin
         if (t_adr[i] < RAM_WORDS) begin
            ram_model[t_adr[i][RAM_ADR_W-1:0]] = wdat;
         end
         if (t_adr[i] == REG_BASE + REG_LED_OFS) begin
            check_value("led", wdat[7:0], led);
         end
      end
      record_result(t_num[i], $sformatf("op %h adr %h", t_op[i], t_adr[i]));
   endtask

   // ------------------------------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------------------------------
   initial begin
      arst_n  = 1'b0;
      uart_rx = 1'b1;
      load_tests();
      // Twelve byte times per command line, plus reset and idle checks
      watchdog_ns = (longint'(n_tests) * 12 + 200) * BYTE_CLKS * 10;
      repeat (16) @(posedge ref_clk);
      #1 arst_n = 1'b1;
      check_idle_after_reset();
      for (int i = 0; i < n_tests; i++) begin
         run_test(i);
      end
      if (n_tests == 0) begin
         $display("no tests were found in the data file");
         fail_count++;
      end
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      wait (watchdog_ns > 0);
      #(watchdog_ns);
      $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== design/soc_fpga_top.sv ====
`timescale 1ns/1ps

module soc_fpga_top import soc_pkg::*; (
   input  logic       ref_clk,
   input  logic       arst_n,
   input  logic       uart_rx,
   output logic       uart_tx,
   output logic [7:0] led
);

   logic [7:0]           rx_data;
   logic                 rx_valid;
   logic [7:0]           tx_data;
   logic                 tx_start;
   logic                 tx_busy;

   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   logic [WB_ADDR_W-1:0] wb_adr;
   logic [WB_DATA_W-1:0] wb_dat_w;
   logic [WB_DATA_W-1:0] wb_dat_r;
   logic                 wb_ack;
   logic                 wb_err;

   logic                 ram_stb;
   logic [WB_DATA_W-1:0] ram_dat_r;
   logic                 ram_ack;
   logic                 reg_stb;
   logic [WB_DATA_W-1:0] reg_dat_r;
   logic                 reg_ack;

   // ------------------------------------------------------------------------
   // Debug UART and bus master
   // ------------------------------------------------------------------------
   uart_rx i_uart_rx (
      .ref_clk  ( ref_clk  ),
      .arst_n   ( arst_n   ),
      .rx       ( uart_rx  ),
      .rx_data  ( rx_data  ),
      .rx_valid ( rx_valid )
   );

   uart_tx i_uart_tx (
      .ref_clk  ( ref_clk  ),
      .arst_n   ( arst_n   ),
      .tx_data  ( tx_data  ),
      .tx_start ( tx_start ),
      .tx       ( uart_tx  ),
      .busy     ( tx_busy  )
   );

   wb_debug_bridge i_bridge (
      .ref_clk  ( ref_clk  ),
      .arst_n   ( arst_n   ),
      .rx_data  ( rx_data  ),
      .rx_valid ( rx_valid ),
      .tx_data  ( tx_data  ),
      .tx_start ( tx_start ),
      .tx_busy  ( tx_busy  ),
      .wb_cyc   ( wb_cyc   ),
      .wb_stb   ( wb_stb   ),
      .wb_we    ( wb_we    ),
      .wb_adr   ( wb_adr   ),
      .wb_dat_w ( wb_dat_w ),
      .wb_dat_r ( wb_dat_r ),
      .wb_ack   ( wb_ack   ),
      .wb_err   ( wb_err   )
   );

   // ------------------------------------------------------------------------
   // Interconnect and slaves
   // ------------------------------------------------------------------------
   wb_addr_decoder i_decoder (
      .m_cyc     ( wb_cyc    ),
      .m_stb     ( wb_stb    ),
      .m_adr     ( wb_adr    ),
      .m_dat_r   ( wb_dat_r  ),
      .m_ack     ( wb_ack    ),
      .m_err     ( wb_err    ),
      .ram_stb   ( ram_stb   ),
      .ram_dat_r ( ram_dat_r ),
      .ram_ack   ( ram_ack   ),
      .reg_stb   ( reg_stb   ),
      .reg_dat_r ( reg_dat_r ),
      .reg_ack   ( reg_ack   ),
      .ref_clk   ( ref_clk   ),
      .arst_n    ( arst_n    )
   );

   scratch_ram i_ram (
      .ref_clk ( ref_clk                ),
      .arst_n  ( arst_n                 ),
      .cyc     ( wb_cyc                 ),
      .stb     ( ram_stb                ),
      .we      ( wb_we                  ),
      .adr     ( wb_adr[RAM_ADR_W-1:0]  ),
      .dat_w   ( wb_dat_w               ),
      .dat_r   ( ram_dat_r              ),
      .ack     ( ram_ack                )
   );

   sys_regs i_regs (
      .ref_clk ( ref_clk   ),
      .arst_n  ( arst_n    ),
      .cyc     ( wb_cyc    ),
      .stb     ( reg_stb   ),
      .we      ( wb_we     ),
      .adr     ( wb_adr[0] ),
      .dat_w   ( wb_dat_w  ),
      .dat_r   ( reg_dat_r ),
      .ack     ( reg_ack   ),
      .led     ( led       )
   );

endmodule

// ==== design/sys_regs.sv ====
`timescale 1ns/1ps

module sys_regs import soc_pkg::*; (
   input  logic                 ref_clk,
   input  logic                 arst_n,
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  logic                 adr,
   input  logic [WB_DATA_W-1:0] dat_w,
   output logic [WB_DATA_W-1:0] dat_r,
   output logic                 ack,
   output logic [7:0]           led
);

   logic access;

   assign access = cyc & stb & ~ack;

   // LED register, only the low byte is stored
   // ID word is read only, writes to it fall through
   always_ff @(posedge ref_clk or negedge arst_n) begin
      if (!arst_n) begin
         led <= 8'h00;
         ack <= 1'b0;
      end else begin
         ack <= access;
         if (access && we && adr == REG_LED_OFS) begin
            led <= dat_w[7:0];
         end
      end
   end

   // Read data lines up with ack
   always_ff @(posedge ref_clk) begin
      if (adr == REG_ID_OFS) begin
         dat_r <= SOC_ID;
      end else begin
         dat_r <= WB_DATA_W'(led);
      end
   end

endmodule

// ==== design/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import soc_pkg::*; (
   input  logic                 ref_clk,
   input  logic                 arst_n,
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  logic [RAM_ADR_W-1:0] adr,
   input  logic [WB_DATA_W-1:0] dat_w,
   output logic [WB_DATA_W-1:0] dat_r,
   output logic                 ack
);

   logic [WB_DATA_W-1:0] mem [RAM_WORDS];
   logic                 access;

   // First cycle of a strobed access only
   assign access = cyc & stb & ~ack;

   always_ff @(posedge ref_clk) begin
      if (access && we) begin
         mem[adr] <= dat_w;
      end
      dat_r <= mem[adr];
   end

   // One-cycle ack, cleared while stb is still up
   always_ff @(posedge ref_clk or negedge arst_n) begin
      if (!arst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

endmodule

// ==== design/wb_addr_decoder.sv ====
`timescale 1ns/1ps

module wb_addr_decoder import soc_pkg::*; (
   input  logic                 m_cyc,
   input  logic                 m_stb,
   input  logic [WB_ADDR_W-1:0] m_adr,
   output logic [WB_DATA_W-1:0] m_dat_r,
   output logic                 m_ack,
   output logic                 m_err,
   output logic                 ram_stb,
   input  logic [WB_DATA_W-1:0] ram_dat_r,
   input  logic                 ram_ack,
   output logic                 reg_stb,
   input  logic [WB_DATA_W-1:0] reg_dat_r,
   input  logic                 reg_ack,
   input  logic                 ref_clk,
   input  logic                 arst_n
);

   logic ram_sel;
   logic reg_sel;
   logic err_q;

   assign ram_sel = (m_adr < WB_ADDR_W'(RAM_WORDS));
   // Register block spans two words from REG_BASE
   assign reg_sel = (m_adr[WB_ADDR_W-1:1] == REG_BASE[WB_ADDR_W-1:1]);

   assign ram_stb = m_stb & ram_sel;
   assign reg_stb = m_stb & reg_sel;

   // Return path follows the selected slave
   always_comb begin
      if (ram_sel) begin
         m_dat_r = ram_dat_r;
         m_ack   = ram_ack;
      end else if (reg_sel) begin
         m_dat_r = reg_dat_r;
         m_ack   = reg_ack;
      end else begin
         m_dat_r = '0;
         m_ack   = 1'b0;
      end
   end

   // Nobody home, answer with a single err pulse
   always_ff @(posedge ref_clk or negedge arst_n) begin
      if (!arst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= m_cyc & m_stb & ~ram_sel & ~reg_sel & ~err_q;
      end
   end

   assign m_err = err_q;

endmodule

// ==== design/wb_debug_bridge.sv ====
`timescale 1ns/1ps

module wb_debug_bridge import soc_pkg::*; (
   input  logic                 ref_clk,
   input  logic                 arst_n,
   input  logic [7:0]           rx_data,
   input  logic                 rx_valid,
   output logic [7:0]           tx_data,
   output logic                 tx_start,
   input  logic                 tx_busy,
   output logic                 wb_cyc,
   output logic                 wb_stb,
   output logic                 wb_we,
   output logic [WB_ADDR_W-1:0] wb_adr,
   output logic [WB_DATA_W-1:0] wb_dat_w,
   input  logic [WB_DATA_W-1:0] wb_dat_r,
   input  logic                 wb_ack,
   input  logic                 wb_err
);

   typedef enum logic [2:0] {
      ST_OPCODE,
      ST_ADDR,
      ST_WDATA,
      ST_BUS,
      ST_REPLY
   } state_t;

   state_t               state;
   logic [1:0]           wdata_cnt;
   logic [2:0]           rsp_cnt;
   // Reply code in the top byte, read data below it
   logic [WB_DATA_W+7:0] rsp_buf;

   // ------------------------------------------------------------------------
   // Command parser, bus master and reply sequencer
   // ------------------------------------------------------------------------
   always_ff @(posedge ref_clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_OPCODE;
         wdata_cnt <= '0;
         rsp_cnt   <= '0;
         rsp_buf   <= '0;
         tx_data   <= '0;
         tx_start  <= 1'b0;
         wb_cyc    <= 1'b0;
         wb_stb    <= 1'b0;
         wb_we     <= 1'b0;
         wb_adr    <= '0;
         wb_dat_w  <= '0;
      end else begin
         tx_start <= 1'b0;
         case (state)
            ST_OPCODE: begin
               if (rx_valid) begin
                  wdata_cnt <= '0;
                  if (rx_data == CMD_WRITE || rx_data == CMD_READ) begin
                     wb_we <= (rx_data == CMD_WRITE);
                     state <= ST_ADDR;
                  end else begin
                     // Unknown opcode is dropped and answered at once
                     rsp_buf <= {RSP_BAD, {WB_DATA_W{1'b0}}};
                     rsp_cnt <= 3'd1;
                     state   <= ST_REPLY;
                  end
               end
            end
            ST_ADDR: begin
               if (rx_valid) begin
                  wb_adr <= rx_data;
                  if (wb_we) begin
                     state <= ST_WDATA;
                  end else begin
                     wb_cyc <= 1'b1;
                     wb_stb <= 1'b1;
                     state  <= ST_BUS;
                  end
               end
            end
            // Data arrives most significant byte first
            ST_WDATA: begin
               if (rx_valid) begin
                  wb_dat_w  <= {wb_dat_w[WB_DATA_W-9:0], rx_data};
                  wdata_cnt <= wdata_cnt + 2'd1;
                  if (wdata_cnt == 2'd3) begin
                     wb_cyc <= 1'b1;
                     wb_stb <= 1'b1;
                     state  <= ST_BUS;
                  end
               end
            end
            // Hold the cycle until the slave or decoder terminates it
            ST_BUS: begin
               if (wb_ack || wb_err) begin
                  wb_cyc <= 1'b0;
                  wb_stb <= 1'b0;
                  state  <= ST_REPLY;
                  if (wb_err) begin
                     rsp_buf <= {RSP_ERR, {WB_DATA_W{1'b0}}};
                     rsp_cnt <= 3'd1;
                  end else if (wb_we) begin
                     rsp_buf <= {RSP_OK, {WB_DATA_W{1'b0}}};
                     rsp_cnt <= 3'd1;
                  end else begin
                     rsp_buf <= {RSP_OK, wb_dat_r};
                     rsp_cnt <= 3'd5;
                  end
               end
            end
            // busy rises one cycle late, so skip the cycle right after a start
            ST_REPLY: begin
               if (!tx_busy && !tx_start) begin
                  tx_data  <= rsp_buf[WB_DATA_W+7:WB_DATA_W];
                  tx_start <= 1'b1;
                  rsp_buf  <= {rsp_buf[WB_DATA_W-1:0], 8'h00};
                  rsp_cnt  <= rsp_cnt - 3'd1;
                  if (rsp_cnt == 3'd1) begin
                     state <= ST_OPCODE;
                  end
               end
            end
            default: state <= ST_OPCODE;
         endcase
      end
   end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import soc_pkg::*; (
   input  logic       ref_clk,
   input  logic       arst_n,
   input  logic [7:0] tx_data,
   input  logic       tx_start,
   output logic       tx,
   output logic       busy
);

   logic [8:0]            shift_reg;
   logic [BAUD_CNT_W-1:0] baud_cnt;
   logic [3:0]            bit_cnt;

   // Bit 0 is the start bit, bits 1 to 8 data, bit 9 the stop bit
   always_ff @(posedge ref_clk or negedge arst_n) begin
      if (!arst_n) begin
         tx        <= 1'b1;
         busy      <= 1'b0;
         shift_reg <= '1;
         baud_cnt  <= '0;
         bit_cnt   <= '0;
      end else if (!busy) begin
         if (tx_start) begin
            // Stop bit rides above the data so it shifts out last
            shift_reg <= {1'b1, tx_data};
            tx        <= 1'b0;
            busy      <= 1'b1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
         end
      end else if (baud_cnt == BAUD_LAST) begin
         baud_cnt <= '0;
         if (bit_cnt == 4'd9) begin
            busy <= 1'b0;
            tx   <= 1'b1;
         end else begin
            tx        <= shift_reg[0];
            shift_reg <= {1'b1, shift_reg[8:1]};
            bit_cnt   <= bit_cnt + 4'd1;
         end
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import soc_pkg::*; (
   input  logic       ref_clk,
   input  logic       arst_n,
   input  logic       rx,
   output logic [7:0] rx_data,
   output logic       rx_valid
);

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP,
      RX_TAIL
   } rx_state_t;

   rx_state_t             state;
   logic [1:0]            rx_sync;
   logic                  rx_line;
   logic [BAUD_CNT_W-1:0] baud_cnt;
   logic [2:0]            bit_cnt;

   // Two-flop synchronizer, idles high like the line
   always_ff @(posedge ref_clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], rx};
      end
   end

   assign rx_line = rx_sync[1];

   always_ff @(posedge ref_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= RX_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         rx_data  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (!rx_line) begin
                  state <= RX_START;
               end
            end
            // Recheck the start bit at its middle to reject glitches
            RX_START: begin
               if (baud_cnt == BAUD_MID) begin
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= rx_line ? RX_IDLE : RX_DATA;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (baud_cnt == BAUD_LAST) begin
                  baud_cnt <= '0;
                  rx_data  <= {rx_line, rx_data[7:1]};
                  bit_cnt  <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            // Low stop bit means a framing error, frame is dropped
            RX_STOP: begin
               if (baud_cnt == BAUD_LAST) begin
                  baud_cnt <= '0;
                  state    <= rx_line ? RX_TAIL : RX_IDLE;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            // Wait out the second half of the stop bit
            RX_TAIL: begin
               if (baud_cnt == BAUD_MID) begin
                  rx_valid <= 1'b1;
                  state    <= RX_IDLE;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

// ==== design/soc_pkg.sv ====
package soc_pkg;

   // ------------------------------------------------------------------------
   // Wishbone bus geometry
   // ------------------------------------------------------------------------
   localparam int WB_ADDR_W = 8;
   localparam int WB_DATA_W = 32;

   // ------------------------------------------------------------------------
   // UART bit timing
   // ------------------------------------------------------------------------
   // Small divider so simulation stays short
   localparam int CLKS_PER_BIT = 8;
   localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

   // Last cycle of a bit, and the cycle that marks the middle of a bit
   localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [BAUD_CNT_W-1:0] BAUD_MID  = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

   // ------------------------------------------------------------------------
   // Address map, in words
   // ------------------------------------------------------------------------
   localparam int RAM_WORDS = 64;
   localparam int RAM_ADR_W = $clog2(RAM_WORDS);

   localparam logic [WB_ADDR_W-1:0] REG_BASE    = 8'h80;
   localparam logic                 REG_ID_OFS  = 1'b0;
   localparam logic                 REG_LED_OFS = 1'b1;

   localparam logic [WB_DATA_W-1:0] SOC_ID = 32'h5AC0_0001;

   // Debug command and reply bytes
   localparam logic [7:0] CMD_WRITE = 8'h57;
   localparam logic [7:0] CMD_READ  = 8'h52;
   localparam logic [7:0] RSP_OK    = 8'h4B;
   localparam logic [7:0] RSP_ERR   = 8'h45;
   localparam logic [7:0] RSP_BAD   = 8'h3F;

endpackage
